/* verification/fetch_stim.txt */
# op  a  b  c  d, all hex. write: addr data strb bresp. read: addr rdata rresp. expect: pc0 count
# redirect: mask(1 trap 2 mret 4 mispredict 8 fence) mret_target misp_addr fence_npc
# resolve: pc taken target. halt: pairs after release. stop: cycles to watch
write    0  11223344  f  0
write    0  aabbccdd  4  0
read     0  11bb3344  0  0
write    0  00001000  f  0
write    8  00003000  f  0
read     8  00003000  0  0
write    c  12345678  f  2
read     c  00000000  2  0
write    4  00000003  1  0
read     4  00000003  0  0
expect   1000  6  0  0
redirect 1  0  0  0
expect   3000  3  0  0
redirect 2  2000  0  0
expect   2000  3  0  0
redirect 4  0  2800  0
expect   2800  3  0  0
redirect 8  0  0  4000
expect   4000  3  0  0
redirect 5  0  8000  0
expect   3000  2  0  0
redirect a  9000  0  a000
expect   9000  2  0  0
redirect c  0  b000  c000
expect   b000  2  0  0
halt     4  0  0  0
resolve  5014  1  6000  0
redirect 4  0  5000  0
expect   5000  3  0  0
expect   6000  2  0  0
resolve  5014  0  0  0
redirect 4  0  5000  0
expect   5000  4  0  0
write    4  00000001  1  0
resolve  7014  1  e000  0
redirect 4  0  7000  0
expect   7000  4  0  0
write    4  00000000  1  0
stop     28  0  0  0
write    0  0000d000  f  0
write    4  00000003  1  0
expect   d000  4  0  0

/* sources.f */
+incdir+include
logic/fetch_pkg.sv
logic/fetch_config.sv
logic/fetch_stage.sv
logic/fetch_buffer.sv
logic/branch_target_cache.sv
logic/fetch_unit.sv
verification/fetch_unit_tb.sv

/* include/fetch_checks.svh */
`ifndef FETCH_CHECKS_SVH
`define FETCH_CHECKS_SVH

// memory model word for an 8-byte aligned address
function automatic logic [63:0] mem_word(input logic [31:0] addr);
  return {(addr + 32'd4) ^ 32'h13, addr ^ 32'h13};
endfunction

task automatic check_pair(input string name, input fetch_pkg::fetch_pair_t expected,
                          input fetch_pkg::fetch_pair_t actual);
  if (expected === actual) begin
    pass_count++;
    $display("PASS %s pc0=%h", name, actual.pc0);
  end else begin
    fail_count++;
    $display("ERROR %s pair expected %h actual %h", name, expected, actual);
  end
endtask

task automatic check_axil_read(input string name, input logic [31:0] exp_data,
                               input logic [1:0] exp_resp, input logic [31:0] data,
                               input logic [1:0] resp);
  if (exp_data === data && exp_resp === resp) begin
    pass_count++;
    $display("PASS %s rdata=%h", name, data);
  end else begin
    fail_count++;
    $display("ERROR %s rdata expected %h actual %h, rresp expected %h actual %h",
             name, exp_data, data, exp_resp, resp);
  end
endtask

task automatic check_request(input string name, input logic exp_spec, input logic exp_fence,
                             input fetch_pkg::mem_req_t actual);
  if (exp_spec === actual.spec && exp_fence === actual.fence) begin
    pass_count++;
    $display("PASS %s addr=%h spec=%h fence=%h", name, actual.addr, actual.spec,
             actual.fence);
  end else begin
    fail_count++;
    $display("ERROR %s imem_req spec expected %h actual %h, fence expected %h actual %h",
             name, exp_spec, actual.spec, exp_fence, actual.fence);
  end
endtask

`endif

/* verification/fetch_unit_tb.sv */
`timescale 1ns/1ps

module fetch_unit_tb;

  logic clock;
  logic reset;
  logic halt;
  fetch_pkg::axil_req_t axil_req;
  fetch_pkg::axil_rsp_t axil_rsp;
  fetch_pkg::mem_req_t imem_req;
  fetch_pkg::mem_rsp_t imem_rsp;
  fetch_pkg::redirect_t redirect;
  fetch_pkg::resolve_t resolve;
  fetch_pkg::fetch_pair_t pair;

  int pass_count = 0;
  int fail_count = 0;
  int record_count = 0;
  integer seed = 95603;

  // the first request after a redirect must carry spec, and fence when fence won
  logic redirect_due = 1'b0;
  logic fence_due = 1'b0;

  string ops[$];
  logic [31:0] arg_a[$];
  logic [31:0] arg_b[$];
  logic [31:0] arg_c[$];
  logic [31:0] arg_d[$];

  // pairs that decode has taken, in order
  fetch_pkg::fetch_pair_t pairs[$];

  `include "fetch_checks.svh"

  fetch_unit #(
    .cache_depth(16),
    .axil_addr_width(4)
  ) i_fetch_unit (
    .clock(clock),
    .reset(reset),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .imem_req(imem_req),
    .imem_rsp(imem_rsp),
    .redirect(redirect),
    .resolve(resolve),
    .halt(halt),
    .pair(pair)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // a pair counts as taken when halt is low at the closing edge
  always @(posedge clock) begin
    if (reset && !halt && (pair.valid0 || pair.valid1)) begin
      pairs.push_back(pair);
    end
  end

  // one request in flight at a time, answered after 1 to 4 cycles
  initial begin
    logic req_seen;
    fetch_pkg::mem_req_t req;
    logic [31:0] mem_addr;
    int mem_left;
    imem_rsp = '0;
    mem_left = 0;
    forever begin
      @(posedge clock);
      req_seen = reset && imem_req.valid;
      req = imem_req;
      if (req_seen && redirect_due) begin
        check_request("redirect request", 1'b1, fence_due, req);
        redirect_due = 1'b0;
      end
      @(negedge clock);
      imem_rsp.ready = 1'b0;
      if (req_seen) begin
        mem_addr = req.addr;
        mem_left = 1 + ({$random(seed)} % 4);
      end
      if (mem_left > 0) begin
        mem_left--;
        if (mem_left == 0) begin
          imem_rsp.ready = 1'b1;
          imem_rsp.rdata = mem_word(mem_addr);
        end
      end
    end
  end

  function automatic fetch_pkg::fetch_pair_t expected_pair(input logic [31:0] pc);
    fetch_pkg::fetch_pair_t p;
    p.pc0 = pc;
    p.pc1 = pc + 32'd4;
    p.instr0 = pc ^ 32'h13;
    p.instr1 = (pc + 32'd4) ^ 32'h13;
    p.valid0 = 1'b1;
    p.valid1 = 1'b1;
    return p;
  endfunction

  task automatic compare_bresp(input string name, input logic [1:0] expected,
                               input logic [1:0] actual);
    if (expected === actual) begin
      pass_count++;
      $display("PASS %s bresp=%h", name, actual);
    end else begin
      fail_count++;
      $display("ERROR %s bresp expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic write_register(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb, output logic [1:0] resp);
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done = 1'b0;
    @(negedge clock);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr = addr;
    axil_req.wvalid = 1'b1;
    axil_req.wdata = data;
    axil_req.wstrb = strb;
    axil_req.bready = 1'b1;
    while (!(aw_done && w_done)) begin
      @(posedge clock);
      if (axil_req.awvalid && axil_rsp.awready) begin
        aw_done = 1'b1;
      end
      if (axil_req.wvalid && axil_rsp.wready) begin
        w_done = 1'b1;
      end
      @(negedge clock);
      axil_req.awvalid = !aw_done;
      axil_req.wvalid = !w_done;
    end
    @(posedge clock);
    while (!axil_rsp.bvalid) @(posedge clock);
    resp = axil_rsp.bresp;
    @(negedge clock);
    axil_req.bready = 1'b0;
  endtask

  task automatic read_register(input logic [31:0] addr, output logic [31:0] data,
                               output logic [1:0] resp);
    @(negedge clock);
    axil_req.arvalid = 1'b1;
    axil_req.araddr = addr;
    axil_req.rready = 1'b1;
    @(posedge clock);
    while (!axil_rsp.arready) @(posedge clock);
    @(negedge clock);
    axil_req.arvalid = 1'b0;
    @(posedge clock);
    while (!axil_rsp.rvalid) @(posedge clock);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(negedge clock);
    axil_req.rready = 1'b0;
  endtask

  task automatic expect_pairs(input string name, input logic [31:0] start, input int count);
    fetch_pkg::fetch_pair_t got;
    for (int k = 0; k < count; k++) begin
      while (pairs.size() == 0) @(negedge clock);
      got = pairs.pop_front();
      check_pair($sformatf("%s pair %0d", name, k), expected_pair(start + 8 * k), got);
    end
  endtask

  // pairs taken up to the redirect cycle belong to the old path
  task automatic drive_redirect(input logic [3:0] mask, input logic [31:0] mret_target,
                                input logic [31:0] misp_addr, input logic [31:0] fence_npc);
    @(negedge clock);
    redirect.trap = mask[0];
    redirect.mret = mask[1];
    redirect.mret_target = mret_target;
    redirect.mispredict = mask[2];
    redirect.mispredict_addr = misp_addr;
    redirect.fence = mask[3];
    redirect.fence_npc = fence_npc;
    redirect_due = 1'b1;
    fence_due = mask[3] && (mask[2:0] == 3'b000);
    @(negedge clock);
    redirect = '0;
    pairs.delete();
  endtask

  task automatic pulse_resolve(input logic [31:0] pc, input logic taken,
                               input logic [31:0] target);
    @(negedge clock);
    resolve.valid = 1'b1;
    resolve.pc = pc;
    resolve.taken = taken;
    resolve.target = target;
    @(negedge clock);
    resolve = '0;
  endtask

  task automatic hold_pair(input string name, input int count);
    fetch_pkg::fetch_pair_t held;
    fetch_pkg::fetch_pair_t seen;
    int cycles;
    while (!(pair.valid0 || pair.valid1)) @(negedge clock);
    pairs.delete();
    halt = 1'b1;
    held = pair;
    seen = pair;
    cycles = 2 + ({$random(seed)} % 8);
    repeat (cycles) begin
      @(negedge clock);
      if (seen === held && pair !== held) begin
        seen = pair;
      end
    end
    halt = 1'b0;
    check_pair($sformatf("%s held %0d cycles", name, cycles), held, seen);
    expect_pairs(name, held.pc0, count);
  endtask

  // only the one response still in flight may turn into a pair
  task automatic verify_fetch_stopped(input string name, input int cycles);
    int late;
    pairs.delete();
    repeat (cycles) @(negedge clock);
    late = pairs.size();
    pairs.delete();
    if (late <= 1) begin
      pass_count++;
      $display("PASS %s %0d pair(s) after fetch disable", name, late);
    end else begin
      fail_count++;
      $display("%s failed, %0d pairs still arrived after fetch was disabled", name, late);
    end
  endtask

  task automatic load_records(output bit ok);
    int fd;
    int code;
    string op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [8*256-1:0] rest;
    fd = $fopen("verification/fetch_stim.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while ($fscanf(fd, "%s", op) == 1) begin
        if (op[0] == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          ops.push_back(op);
          arg_a.push_back(a);
          arg_b.push_back(b);
          arg_c.push_back(c);
          arg_d.push_back(d);
        end
      end
      $fclose(fd);
      record_count = ops.size();
    end
  endtask

  task automatic run_record(input int i);
    string name;
    logic [31:0] data;
    logic [1:0] resp;
    name = $sformatf("%s %0d", ops[i], i);
    case (ops[i])
      "write": begin
        write_register(arg_a[i], arg_b[i], arg_c[i][3:0], resp);
        compare_bresp(name, arg_d[i][1:0], resp);
      end
      "read": begin
        read_register(arg_a[i], data, resp);
        check_axil_read(name, arg_b[i], arg_c[i][1:0], data, resp);
      end
      "expect": expect_pairs(name, arg_a[i], arg_b[i]);
      "redirect": drive_redirect(arg_a[i][3:0], arg_b[i], arg_c[i], arg_d[i]);
      "resolve": pulse_resolve(arg_a[i], arg_b[i][0], arg_c[i]);
      "halt": hold_pair(name, arg_a[i]);
      "stop": verify_fetch_stopped(name, arg_a[i]);
      default: begin
        fail_count++;
        $display("record %0d has an unknown operation %s", i, ops[i]);
      end
    endcase
  endtask

  initial begin
    bit ok;
    reset = 1'b0;
    halt = 1'b0;
    axil_req = '0;
    redirect = '0;
    resolve = '0;
    load_records(ok);
    if (ok) begin
      repeat (16) @(negedge clock);
      reset = 1'b1;
      repeat (2) @(negedge clock);
      for (int i = 0; i < record_count; i++) begin
        run_record(i);
      end
    end else begin
      fail_count++;
      $display("could not open the stimulus file verification/fetch_stim.txt");
    end
    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    wait (record_count > 0);
    repeat (record_count * 200) @(posedge clock);
    $display("timeout: the tests did not finish within %0d cycles", record_count * 200);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
  parameter int cache_depth = 16,
  parameter int axil_addr_width = 4
) (
  input logic clock,
  input logic reset,
  input fetch_pkg::axil_req_t axil_req,
  output fetch_pkg::axil_rsp_t axil_rsp,
  output fetch_pkg::mem_req_t imem_req,
  input fetch_pkg::mem_rsp_t imem_rsp,
  input fetch_pkg::redirect_t redirect,
  input fetch_pkg::resolve_t resolve,
  input logic halt,
  output fetch_pkg::fetch_pair_t pair
);

  fetch_pkg::fetch_cfg_t cfg;
  fetch_pkg::pred_t pred0;
  fetch_pkg::pred_t pred1;
  logic flush;
  logic stall;
  logic [31:0] pc_issued;

  fetch_config #(
    .axil_addr_width(axil_addr_width)
  ) i_fetch_config (
    .clock(clock),
    .reset(reset),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .cfg(cfg)
  );

  fetch_stage i_fetch_stage (
    .clock(clock),
    .reset(reset),
    .cfg(cfg),
    .redirect(redirect),
    .pred0(pred0),
    .pred1(pred1),
    .imem_rsp(imem_rsp),
    .stall(stall),
    .imem_req(imem_req),
    .flush(flush),
    .pc_issued(pc_issued)
  );

  fetch_buffer i_fetch_buffer (
    .clock(clock),
    .reset(reset),
    .halt(halt),
    .flush(flush),
    .pc_issued(pc_issued),
    .imem_rsp(imem_rsp),
    .pair(pair),
    .stall(stall)
  );

  branch_target_cache #(
    .cache_depth(cache_depth)
  ) i_branch_target_cache (
    .clock(clock),
    .reset(reset),
    .cfg(cfg),
    .lookup_pc0(pair.pc0),
    .lookup_pc1(pair.pc1),
    .resolve(resolve),
    .pred0(pred0),
    .pred1(pred1)
  );

endmodule

/* logic/branch_target_cache.sv */
`timescale 1ns/1ps

module branch_target_cache #(
  parameter int cache_depth = 16
) (
  input logic clock,
  input logic reset,
  input fetch_pkg::fetch_cfg_t cfg,
  input logic [31:0] lookup_pc0,
  input logic [31:0] lookup_pc1,
  input fetch_pkg::resolve_t resolve,
  output fetch_pkg::pred_t pred0,
  output fetch_pkg::pred_t pred1
);

  localparam int idx_w = $clog2(cache_depth);
  localparam int tag_w = 30 - idx_w;

  logic taken_bit [cache_depth];
  logic [tag_w-1:0] tag [cache_depth];
  logic [31:0] target [cache_depth];

  logic [idx_w-1:0] idx0;
  logic [idx_w-1:0] idx1;
  logic [idx_w-1:0] upd_idx;
  logic [tag_w-1:0] upd_tag;
  logic upd_hit;

  assign idx0 = lookup_pc0[idx_w+1:2];
  assign idx1 = lookup_pc1[idx_w+1:2];
  assign upd_idx = resolve.pc[idx_w+1:2];
  assign upd_tag = resolve.pc[31:idx_w+2];
  assign upd_hit = taken_bit[upd_idx] && (tag[upd_idx] == upd_tag);

  always_comb begin
    pred0.taken = cfg.pred_en && taken_bit[idx0] && (tag[idx0] == lookup_pc0[31:idx_w+2]);
    pred0.target = target[idx0];
    pred1.taken = cfg.pred_en && taken_bit[idx1] && (tag[idx1] == lookup_pc1[31:idx_w+2]);
    pred1.target = target[idx1];
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < cache_depth; i++) begin
        taken_bit[i] <= 1'b0;
      end
    end else if (resolve.valid) begin
      if (resolve.taken) begin
        taken_bit[upd_idx] <= 1'b1;
      end else if (upd_hit) begin
        // not taken only evicts its own entry, not an alias
        taken_bit[upd_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (resolve.valid && resolve.taken) begin
      tag[upd_idx] <= upd_tag;
      target[upd_idx] <= resolve.target;
    end
  end

endmodule

/* logic/fetch_buffer.sv */
`timescale 1ns/1ps

module fetch_buffer (
  input logic clock,
  input logic reset,
  input logic halt,
  input logic flush,
  input logic [31:0] pc_issued,
  input fetch_pkg::mem_rsp_t imem_rsp,
  output fetch_pkg::fetch_pair_t pair,
  output logic stall
);

  logic accept;
  logic skid_valid;
  logic [31:0] skid_pc;
  logic [63:0] skid_data;

  // a target with bit 2 set starts in the upper half, so slot 0 is empty
  function automatic fetch_pkg::fetch_pair_t split(input logic valid, input logic [31:0] pc,
                                                   input logic [63:0] data);
    fetch_pkg::fetch_pair_t p;
    p.pc0 = '0;
    p.pc1 = '0;
    p.instr0 = fetch_pkg::nop_instr;
    p.instr1 = fetch_pkg::nop_instr;
    p.valid0 = 1'b0;
    p.valid1 = 1'b0;
    if (valid) begin
      p.pc0 = {pc[31:3], 3'b000};
      p.pc1 = {pc[31:3], 3'b100};
      p.instr1 = data[63:32];
      p.valid1 = 1'b1;
      if (!pc[2]) begin
        p.instr0 = data[31:0];
        p.valid0 = 1'b1;
      end
    end
    return p;
  endfunction

  assign accept = imem_rsp.ready && !flush;
  assign stall = halt || skid_valid;

  always_ff @(posedge clock) begin
    if (!reset) begin
      pair <= split(1'b0, '0, '0);
      skid_valid <= 1'b0;
    end else if (flush) begin
      pair <= split(1'b0, '0, '0);
      skid_valid <= 1'b0;
    end else if (halt) begin
      if (accept) begin
        skid_valid <= 1'b1;
      end
    end else if (skid_valid) begin
      pair <= split(1'b1, skid_pc, skid_data);
      skid_valid <= accept;
    end else begin
      pair <= split(accept, pc_issued, imem_rsp.rdata);
    end
  end

  always_ff @(posedge clock) begin
    if (accept && (halt || skid_valid)) begin
      skid_pc <= pc_issued;
      skid_data <= imem_rsp.rdata;
    end
  end

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
  input logic clock,
  input logic reset,
  input fetch_pkg::fetch_cfg_t cfg,
  input fetch_pkg::redirect_t redirect,
  input fetch_pkg::pred_t pred0,
  input fetch_pkg::pred_t pred1,
  input fetch_pkg::mem_rsp_t imem_rsp,
  input logic stall,
  output fetch_pkg::mem_req_t imem_req,
  output logic flush,
  output logic [31:0] pc_issued
);

  fetch_pkg::fetch_state_t state;
  fetch_pkg::fetch_state_t state_next;
  logic [31:0] pc;
  logic [31:0] pc_next;
  logic [31:0] pc_sel;
  logic [31:0] target;
  logic outstanding;
  logic outstanding_next;
  logic redirect_now;
  logic fence_now;
  logic issue;
  logic done;
  logic parked;

  always_comb begin
    redirect_now = 1'b1;
    fence_now = 1'b0;
    target = pc;
    if (redirect.trap) begin
      target = cfg.trap_vector;
    end else if (redirect.mret) begin
      target = redirect.mret_target;
    end else if (redirect.mispredict) begin
      target = redirect.mispredict_addr;
    end else if (redirect.fence) begin
      fence_now = 1'b1;
      target = redirect.fence_npc;
    end else if (pred0.taken) begin
      target = pred0.target;
    end else if (pred1.taken) begin
      target = pred1.target;
    end else begin
      redirect_now = 1'b0;
    end

    pc_sel = redirect_now ? target : pc;
    parked = (state == fetch_pkg::ctrl) || (state == fetch_pkg::inv);
    // the last request has answered, or nothing is in flight at all
    done = imem_rsp.ready || !outstanding;
    state_next = state;
    issue = 1'b0;

    case (state)
      fetch_pkg::idle: begin
        if (cfg.fetch_en) begin
          pc_sel = cfg.boot_pc;
          issue = 1'b1;
          state_next = fetch_pkg::busy;
        end
      end
      fetch_pkg::busy: begin
        if (done) begin
          if (!cfg.fetch_en) begin
            state_next = fetch_pkg::idle;
          end else if (!stall) begin
            issue = 1'b1;
          end
        end else if (redirect_now) begin
          state_next = fence_now ? fetch_pkg::inv : fetch_pkg::ctrl;
        end
      end
      default: begin
        // stale response is back, so the saved target can go out
        if (imem_rsp.ready) begin
          state_next = cfg.fetch_en ? fetch_pkg::busy : fetch_pkg::idle;
          issue = cfg.fetch_en && !stall;
        end
      end
    endcase

    pc_next = issue ? {pc_sel[31:3], 3'b000} + 32'd8 : pc_sel;
    outstanding_next = issue || (outstanding && !imem_rsp.ready);

    imem_req.valid = issue;
    imem_req.addr = {pc_sel[31:3], 3'b000};
    imem_req.spec = redirect_now || parked;
    imem_req.fence = fence_now || (state == fetch_pkg::inv);

    // the returning stale word is dropped in the buffer by a second flush
    flush = redirect_now || (parked && imem_rsp.ready);
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= fetch_pkg::idle;
      pc <= '0;
      outstanding <= 1'b0;
    end else begin
      state <= state_next;
      pc <= pc_next;
      outstanding <= outstanding_next;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      pc_issued <= pc_sel;
    end
  end

endmodule

/* logic/fetch_config.sv */
`timescale 1ns/1ps

module fetch_config #(
  parameter int axil_addr_width = 4
) (
  input logic clock,
  input logic reset,
  input fetch_pkg::axil_req_t axil_req,
  output fetch_pkg::axil_rsp_t axil_rsp,
  output fetch_pkg::fetch_cfg_t cfg
);

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  logic ready_en;
  logic aw_got;
  logic w_got;
  logic [axil_addr_width-1:0] aw_addr;
  logic [31:0] w_data;
  logic [3:0] w_strb;
  logic [31:0] boot_pc;
  logic [1:0] control;
  logic [31:0] trap_vector;
  logic [axil_addr_width-1:0] ar_addr;

  function automatic logic [31:0] apply_strb(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  // readies stay low until the cycle after reset is released
  assign axil_rsp.awready = ready_en && !aw_got && !axil_rsp.bvalid;
  assign axil_rsp.wready = ready_en && !w_got && !axil_rsp.bvalid;
  assign axil_rsp.arready = ready_en && !axil_rsp.rvalid;
  assign ar_addr = axil_req.araddr[axil_addr_width-1:0];

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_en <= 1'b0;
      aw_got <= 1'b0;
      w_got <= 1'b0;
      axil_rsp.bvalid <= 1'b0;
      axil_rsp.bresp <= resp_okay;
      axil_rsp.rvalid <= 1'b0;
      axil_rsp.rdata <= '0;
      axil_rsp.rresp <= resp_okay;
      boot_pc <= '0;
      control <= '0;
      trap_vector <= '0;
    end else begin
      ready_en <= 1'b1;
      if (axil_req.awvalid && axil_rsp.awready) begin
        aw_got <= 1'b1;
        aw_addr <= axil_req.awaddr[axil_addr_width-1:0];
      end
      if (axil_req.wvalid && axil_rsp.wready) begin
        w_got <= 1'b1;
        w_data <= axil_req.wdata;
        w_strb <= axil_req.wstrb;
      end
      // both halves are in, so the write lands and the response is raised
      if (aw_got && w_got) begin
        aw_got <= 1'b0;
        w_got <= 1'b0;
        axil_rsp.bvalid <= 1'b1;
        axil_rsp.bresp <= resp_okay;
        if (aw_addr == fetch_pkg::boot_pc_addr[axil_addr_width-1:0]) begin
          boot_pc <= apply_strb(boot_pc, w_data, w_strb);
        end else if (aw_addr == fetch_pkg::control_addr[axil_addr_width-1:0]) begin
          if (w_strb[0]) begin
            control <= w_data[1:0];
          end
        end else if (aw_addr == fetch_pkg::trap_vector_addr[axil_addr_width-1:0]) begin
          trap_vector <= apply_strb(trap_vector, w_data, w_strb);
        end else begin
          axil_rsp.bresp <= resp_slverr;
        end
      end else if (axil_rsp.bvalid && axil_req.bready) begin
        axil_rsp.bvalid <= 1'b0;
      end
      if (axil_req.arvalid && axil_rsp.arready) begin
        axil_rsp.rvalid <= 1'b1;
        axil_rsp.rresp <= resp_okay;
        if (ar_addr == fetch_pkg::boot_pc_addr[axil_addr_width-1:0]) begin
          axil_rsp.rdata <= boot_pc;
        end else if (ar_addr == fetch_pkg::control_addr[axil_addr_width-1:0]) begin
          axil_rsp.rdata <= {30'b0, control};
        end else if (ar_addr == fetch_pkg::trap_vector_addr[axil_addr_width-1:0]) begin
          axil_rsp.rdata <= trap_vector;
        end else begin
          axil_rsp.rdata <= '0;
          axil_rsp.rresp <= resp_slverr;
        end
      end else if (axil_rsp.rvalid && axil_req.rready) begin
        axil_rsp.rvalid <= 1'b0;
      end
    end
  end

  assign cfg.boot_pc = boot_pc;
  assign cfg.fetch_en = control[0];
  assign cfg.pred_en = control[1];
  assign cfg.trap_vector = trap_vector;

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

  localparam int xlen = 32;
  localparam int fetch_width = 64;

  // addi x0, x0, 0
  localparam logic [31:0] nop_instr = 32'h0000_0013;

  localparam logic [7:0] boot_pc_addr = 8'h00;
  localparam logic [7:0] control_addr = 8'h04;
  localparam logic [7:0] trap_vector_addr = 8'h08;

  typedef enum logic [1:0] {
    idle = 2'd0,
    busy = 2'd1,
    ctrl = 2'd2,
    inv = 2'd3
  } fetch_state_t;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] addr;
    logic spec;
    logic fence;
  } mem_req_t;

  typedef struct packed {
    logic ready;
    logic [fetch_width-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic trap;
    logic mret;
    logic [xlen-1:0] mret_target;
    logic mispredict;
    logic [xlen-1:0] mispredict_addr;
    logic fence;
    logic [xlen-1:0] fence_npc;
  } redirect_t;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    logic taken;
    logic [xlen-1:0] target;
  } resolve_t;

  typedef struct packed {
    logic taken;
    logic [xlen-1:0] target;
  } pred_t;

  typedef struct packed {
    logic [xlen-1:0] pc0;
    logic [xlen-1:0] pc1;
    logic [31:0] instr0;
    logic [31:0] instr1;
    logic valid0;
    logic valid1;
  } fetch_pair_t;

  typedef struct packed {
    logic [xlen-1:0] boot_pc;
    logic fetch_en;
    logic pred_en;
    logic [xlen-1:0] trap_vector;
  } fetch_cfg_t;

  typedef struct packed {
    logic awvalid;
    logic [xlen-1:0] awaddr;
    logic wvalid;
    logic [xlen-1:0] wdata;
    logic [3:0] wstrb;
    logic bready;
    logic arvalid;
    logic [xlen-1:0] araddr;
    logic rready;
  } axil_req_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic arready;
    logic rvalid;
    logic [xlen-1:0] rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

endpackage
